// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_soc_mem_top
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert -Wno-fatal

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

# Build and run, exit status follows the testbench result
sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

// File: filelist.f
+incdir+.
soc_bus_pkg.sv
soc_prog_pkg.sv
mem_port_if.sv
ram_latency_emu.sv
main_memory.sv
uart_program_loader.sv
iomem_fabric.sv
soc_mem_top.sv
soc_mem_asserts.sv
tb_soc_mem_top.sv

// File: iomem_fabric.sv
`timescale 1ns/1ps
`include "soc_cfg.svh"

module iomem_fabric (
  input  logic                     clk_i,
  input  logic                     rst_n,
  input  logic                     sys_rst_n_i,
  input  logic                     iomem_valid_i,
  input  soc_bus_pkg::strb_t       iomem_wstrb_i,
  input  soc_bus_pkg::iomem_addr_u iomem_addr_i,
  input  soc_bus_pkg::word_t       iomem_wdata_i,
  output logic                     iomem_ready_o,
  output soc_bus_pkg::word_t       iomem_rdata_o,
  mem_port_if.fabric               mem
);

  localparam soc_bus_pkg::word_t RAM_BASE = `SOC_RAM_BASE;
  localparam soc_bus_pkg::word_t RAM_MASK = `SOC_RAM_MASK;
  localparam soc_bus_pkg::word_t TIMER_LO = `SOC_TIMER_LO_ADDR;
  localparam soc_bus_pkg::word_t TIMER_HI = `SOC_TIMER_HI_ADDR;

  soc_bus_pkg::bus_region_e region;
  logic                     ram_sel;
  logic                     ram_ready;
  logic                     line_rst_n;
  logic [63:0]              timer_q;

  //////////////////////////////
  // Address decode
  //////////////////////////////

  always_comb begin
    region = soc_bus_pkg::REGION_NONE;
    if ((iomem_addr_i.ram.tag & ~RAM_MASK[31:20]) == RAM_BASE[31:20]) begin
      region = soc_bus_pkg::REGION_RAM;
    end else if (iomem_addr_i.io.base == TIMER_LO[31:4] &&
                 iomem_addr_i.io.byte_off == 2'b00 &&
                 (iomem_addr_i.io.reg_idx == TIMER_LO[3:2] ||
                  iomem_addr_i.io.reg_idx == TIMER_HI[3:2])) begin
      region = soc_bus_pkg::REGION_TIMER;
    end
  end

  assign ram_sel = iomem_valid_i & (region == soc_bus_pkg::REGION_RAM);

  // Memory port, active only for RAM hits
  assign mem.wr_strb = ram_sel ? iomem_wstrb_i : 4'b0000;
  assign mem.rd_en   = ram_sel & ~(|iomem_wstrb_i);
  assign mem.addr    = iomem_addr_i.ram.word_idx[$bits(soc_prog_pkg::word_index_t)-1:0];
  assign mem.wdata   = iomem_wdata_i;

  // Latency line restarts on board reset or program load
  assign line_rst_n = rst_n & sys_rst_n_i;

  ram_latency_emu i_ram_latency_emu (
    .clk_i       (clk_i),
    .rst_n       (line_rst_n),
    .ram_req_i   (ram_sel & ~ram_ready),
    .ram_ready_o (ram_ready)
  );

  // Free-running cycle timer
  always_ff @(posedge clk_i) begin
    if (!sys_rst_n_i) begin
      timer_q <= 64'h0;
    end else begin
      timer_q <= timer_q + 64'h1;
    end
  end

  //////////////////////////////
  // Read data and ready
  //////////////////////////////

  always_comb begin
    case (region)
      soc_bus_pkg::REGION_RAM: iomem_rdata_o = mem.rdata;
      soc_bus_pkg::REGION_TIMER: begin
        if (iomem_addr_i.io.reg_idx == TIMER_HI[3:2]) begin
          iomem_rdata_o = timer_q[63:32];
        end else begin
          iomem_rdata_o = timer_q[31:0];
        end
      end
      default: iomem_rdata_o = 32'h0;
    endcase
  end

  // Timer and unmapped answer in the same cycle
  assign iomem_ready_o = ram_ready |
                         (iomem_valid_i & (region != soc_bus_pkg::REGION_RAM));

endmodule

// File: main_memory.sv
`timescale 1ns/1ps
`include "soc_cfg.svh"

module main_memory (
  input  logic                      clk_i,
  input  logic                      prog_we_i,
  input  soc_prog_pkg::word_index_t prog_addr_i,
  input  soc_bus_pkg::word_t        prog_wdata_i,
  mem_port_if.memory                mem
);

  soc_bus_pkg::word_t mem_q [`SOC_RAM_DEPTH];
  soc_bus_pkg::word_t rdata_q;

  //////////////////////////////
  // Write port
  //////////////////////////////

  always_ff @(posedge clk_i) begin
    if (prog_we_i) begin
      // Loader writes whole words
      mem_q[prog_addr_i] <= prog_wdata_i;
    end else begin
      for (int b = 0; b < 4; b++) begin
        if (mem.wr_strb[b]) begin
          mem_q[mem.addr][8*b +: 8] <= mem.wdata[8*b +: 8];
        end
      end
    end
  end

  //////////////////////////////
  // Read port
  //////////////////////////////

  // Holds last read word between reads
  always_ff @(posedge clk_i) begin
    if (mem.rd_en) begin
      rdata_q <= mem_q[mem.addr];
    end
  end

  assign mem.rdata = rdata_q;

endmodule

// File: mem_port_if.sv
`timescale 1ns/1ps

interface mem_port_if;

  soc_bus_pkg::strb_t        wr_strb;
  logic                      rd_en;
  soc_prog_pkg::word_index_t addr;
  soc_bus_pkg::word_t        wdata;
  soc_bus_pkg::word_t        rdata;

  // Bus side
  modport fabric (
    output wr_strb,
    output rd_en,
    output addr,
    output wdata,
    input  rdata
  );

  // RAM side
  modport memory (
    input  wr_strb,
    input  rd_en,
    input  addr,
    input  wdata,
    output rdata
  );

endinterface

// File: ram_latency_emu.sv
`timescale 1ns/1ps
`include "soc_cfg.svh"

module ram_latency_emu (
  input  logic clk_i,
  input  logic rst_n,
  input  logic ram_req_i,
  output logic ram_ready_o
);

  localparam int DELAY = `SOC_RAM_DELAY;

  logic [DELAY-1:0] shift_q;

  // The leading request bit reaches the last stage after DELAY cycles.
  // Later bits are dropped by the clear that follows ready.
  always_ff @(posedge clk_i) begin
    if (!rst_n) begin
      shift_q <= '0;
    end else if (ram_ready_o) begin
      shift_q <= '0;
    end else begin
      shift_q <= {shift_q[DELAY-2:0], ram_req_i};
    end
  end

  // One-cycle ready
  assign ram_ready_o = shift_q[DELAY-1];

endmodule

// File: soc_bus_pkg.sv
package soc_bus_pkg;

  // Byte strobe and data word of the core bus
  typedef logic [3:0]  strb_t;
  typedef logic [31:0] word_t;

  // RAM view of an address
  typedef struct packed {
    logic [11:0] tag;
    logic [17:0] word_idx;
    logic [1:0]  byte_off;
  } iomem_ram_view_t;

  // I/O register view of an address
  typedef struct packed {
    logic [27:0] base;
    logic [1:0]  reg_idx;
    logic [1:0]  byte_off;
  } iomem_io_view_t;

  // Same bus address, decoded per region
  typedef union packed {
    iomem_ram_view_t ram;
    iomem_io_view_t  io;
  } iomem_addr_u;

  typedef enum logic [1:0] {
    REGION_RAM,
    REGION_TIMER,
    REGION_NONE
  } bus_region_e;

endpackage

// File: soc_cfg.svh
`ifndef SOC_CFG_SVH
`define SOC_CFG_SVH

//////////////////////////////
// Main memory
//////////////////////////////

// Number of 32-bit words
`define SOC_RAM_DEPTH 4096

// Cycles from first valid to ready for slow RAM
`define SOC_RAM_DELAY 16

// RAM region, low 20 bits free
`define SOC_RAM_BASE 32'h4000_0000
`define SOC_RAM_MASK 32'h000F_FFFF

//////////////////////////////
// I/O registers
//////////////////////////////

// Cycle timer halves
`define SOC_TIMER_LO_ADDR 32'h3000_0000
`define SOC_TIMER_HI_ADDR 32'h3000_0004

//////////////////////////////
// Program loader
//////////////////////////////

`define SOC_CLKS_PER_BIT 8
`define SOC_PROG_START 8'hA5

`endif

// File: soc_mem_asserts.sv
`timescale 1ns/1ps
`include "soc_cfg.svh"

module soc_mem_asserts (
  input logic               clk_i,
  input logic               rst_n,
  input logic               iomem_valid_i,
  input soc_bus_pkg::word_t iomem_addr_i,
  input logic               iomem_ready_i,
  input logic               prog_mode_led_i,
  input logic               core_rst_n_i
);

  soc_bus_pkg::bus_region_e region;
  logic                     ram_ready;
  int                       fail_cnt = 0;

  always_comb begin
    if ((iomem_addr_i & ~`SOC_RAM_MASK) == `SOC_RAM_BASE) begin
      region = soc_bus_pkg::REGION_RAM;
    end else if (iomem_addr_i == `SOC_TIMER_LO_ADDR || iomem_addr_i == `SOC_TIMER_HI_ADDR) begin
      region = soc_bus_pkg::REGION_TIMER;
    end else begin
      region = soc_bus_pkg::REGION_NONE;
    end
  end

  assign ram_ready = iomem_ready_i & (region == soc_bus_pkg::REGION_RAM);

  ready_with_valid: assert property (@(negedge clk_i) disable iff (!rst_n)
    iomem_ready_i |-> iomem_valid_i)
    else begin
      $error("bus ready without a pending valid");
      fail_cnt++;
    end

  led_holds_core: assert property (@(negedge clk_i) disable iff (!rst_n)
    prog_mode_led_i |-> !core_rst_n_i)
    else begin
      $error("programming LED on while core is out of reset");
      fail_cnt++;
    end

  ram_ready_single: assert property (@(negedge clk_i) disable iff (!rst_n)
    ram_ready |=> !ram_ready)
    else begin
      $error("RAM ready high in two consecutive cycles");
      fail_cnt++;
    end

endmodule

bind soc_mem_top soc_mem_asserts i_soc_mem_asserts (
  .clk_i           (clk_i),
  .rst_n           (rst_n),
  .iomem_valid_i   (iomem_valid_i),
  .iomem_addr_i    (iomem_addr_i),
  .iomem_ready_i   (iomem_ready_o),
  .prog_mode_led_i (prog_mode_led_o),
  .core_rst_n_i    (core_rst_n_o)
);

// File: soc_mem_top.sv
`timescale 1ns/1ps

module soc_mem_top (
  input  logic               clk_i,
  input  logic               rst_n,
  input  logic               program_rx_i,
  input  logic               iomem_valid_i,
  input  soc_bus_pkg::strb_t iomem_wstrb_i,
  input  soc_bus_pkg::word_t iomem_addr_i,
  input  soc_bus_pkg::word_t iomem_wdata_i,
  output logic               iomem_ready_o,
  output soc_bus_pkg::word_t iomem_rdata_o,
  output logic               prog_mode_led_o,
  output logic               core_rst_n_o
);

  logic                      prog_we;
  soc_prog_pkg::word_index_t prog_addr;
  soc_bus_pkg::word_t        prog_wdata;

  mem_port_if i_mem_port_if ();

  // Bus decode, timer and RAM latency
  iomem_fabric i_iomem_fabric (
    .clk_i         (clk_i),
    .rst_n         (rst_n),
    .sys_rst_n_i   (core_rst_n_o),
    .iomem_valid_i (iomem_valid_i),
    .iomem_wstrb_i (iomem_wstrb_i),
    .iomem_addr_i  (iomem_addr_i),
    .iomem_wdata_i (iomem_wdata_i),
    .iomem_ready_o (iomem_ready_o),
    .iomem_rdata_o (iomem_rdata_o),
    .mem           (i_mem_port_if.fabric)
  );

  main_memory i_main_memory (
    .clk_i        (clk_i),
    .prog_we_i    (prog_we),
    .prog_addr_i  (prog_addr),
    .prog_wdata_i (prog_wdata),
    .mem          (i_mem_port_if.memory)
  );

  // Serial program load
  uart_program_loader i_uart_program_loader (
    .clk_i        (clk_i),
    .rst_n        (rst_n),
    .program_rx_i (program_rx_i),
    .prog_we_o    (prog_we),
    .prog_addr_o  (prog_addr),
    .prog_wdata_o (prog_wdata),
    .prog_mode_o  (prog_mode_led_o),
    .sys_rst_n_o  (core_rst_n_o)
  );

endmodule

// File: soc_prog_pkg.sv
`include "soc_cfg.svh"

package soc_prog_pkg;

  typedef enum logic [2:0] {
    LD_IDLE,
    LD_COUNT,
    LD_DATA,
    LD_DONE
  } loader_state_e;

  // Index of a 32-bit word in main memory
  typedef logic [$clog2(`SOC_RAM_DEPTH)-1:0] word_index_t;

  // Serial byte and its lane inside a word
  typedef logic [7:0] byte_t;
  typedef logic [1:0] byte_lane_t;

endpackage

// File: tb_soc_mem_top.sv
`timescale 1ns/1ps
`include "soc_cfg.svh"

module tb_soc_mem_top;

  typedef soc_bus_pkg::word_t word_t;
  typedef soc_bus_pkg::strb_t strb_t;

  localparam int BUS_TIMEOUT  = 100;
  localparam int LOAD_TIMEOUT = 200;
  localparam int CPB          = `SOC_CLKS_PER_BIT;
  localparam word_t RAM_BASE  = `SOC_RAM_BASE;
  localparam word_t RAM_MASK  = `SOC_RAM_MASK;
  localparam word_t UNMAPPED  = 32'h2000_0010;

  typedef enum {OP_WR, OP_RD_RAM, OP_RD_EXP} op_kind_e;

  typedef struct {
    op_kind_e kind;
    word_t    addr;
    strb_t    strb;
    word_t    data;
    word_t    exp;
  } op_t;

  logic  clk_i;
  logic  rst_n;
  logic  program_rx_i;
  logic  iomem_valid_i;
  strb_t iomem_wstrb_i;
  word_t iomem_addr_i;
  word_t iomem_wdata_i;
  logic  iomem_ready_o;
  word_t iomem_rdata_o;
  logic  prog_mode_led_o;
  logic  core_rst_n_o;

  // Reference copy of RAM contents
  word_t model_mem [`SOC_RAM_DEPTH];
  op_t   ops [$];
  int    cyc_cnt = 0;

  soc_mem_top i_soc_mem_top (
    .clk_i           (clk_i),
    .rst_n           (rst_n),
    .program_rx_i    (program_rx_i),
    .iomem_valid_i   (iomem_valid_i),
    .iomem_wstrb_i   (iomem_wstrb_i),
    .iomem_addr_i    (iomem_addr_i),
    .iomem_wdata_i   (iomem_wdata_i),
    .iomem_ready_o   (iomem_ready_o),
    .iomem_rdata_o   (iomem_rdata_o),
    .prog_mode_led_o (prog_mode_led_o),
    .core_rst_n_o    (core_rst_n_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin
    cyc_cnt <= cyc_cnt + 1;
  end

  //////////////////////////////
  // Reference rules
  //////////////////////////////

  function automatic bit is_ram(input word_t addr);
    return (addr & ~RAM_MASK) == RAM_BASE;
  endfunction

  function automatic int ram_index(input word_t addr);
    return (addr >> 2) % `SOC_RAM_DEPTH;
  endfunction

  function automatic int expected_latency(input word_t addr);
    return is_ram(addr) ? `SOC_RAM_DELAY : 1;
  endfunction

  // Strobed bytes replaced, the others kept
  function automatic word_t merge_bytes(input word_t old_w, input word_t new_w, input strb_t strb);
    word_t res;
    int    b;
    res = old_w;
    for (b = 0; b < 4; b++) begin
      if (strb[b]) begin
        res[8*b +: 8] = new_w[8*b +: 8];
      end
    end
    return res;
  endfunction

  //////////////////////////////
  // Checks and drivers
  //////////////////////////////

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("SIMULATION FAILED");
    $fatal(1);
  endtask

  task automatic check_word(input string what, input word_t got, input word_t exp);
    assert (got === exp)
      else abort_run($sformatf("FAIL %0t: %s read %h, expected %h", $time, what, got, exp));
  endtask

  task automatic check_loading(input string when);
    assert (prog_mode_led_o === 1'b1 && core_rst_n_o === 1'b0)
      else abort_run($sformatf("FAIL %0t: LED %b core reset %b after %s",
                               $time, prog_mode_led_o, core_rst_n_o, when));
  endtask

  // 8N1, LSB first
  task automatic send_byte(input logic [7:0] data);
    int i;
    program_rx_i = 1'b0;
    repeat (CPB) @(negedge clk_i);
    for (i = 0; i < 8; i++) begin
      program_rx_i = data[i];
      repeat (CPB) @(negedge clk_i);
    end
    program_rx_i = 1'b1;
    repeat (CPB) @(negedge clk_i);
  endtask

  task automatic load_program(input word_t words [$]);
    int n;
    int w;
    int b;
    int waited;
    n = words.size();
    send_byte(`SOC_PROG_START);
    send_byte(8'(n));
    check_loading("count byte");
    for (w = 0; w < n; w++) begin
      for (b = 0; b < 4; b++) begin
        send_byte(words[w][8*b +: 8]);
        if (w * 4 + b < 4 * n - 1) begin
          check_loading($sformatf("byte %0d of word %0d", b, w));
        end
      end
    end
    waited = 0;
    while (prog_mode_led_o !== 1'b0 && waited < LOAD_TIMEOUT) begin
      @(negedge clk_i);
      waited++;
    end
    if (prog_mode_led_o !== 1'b0) begin
      abort_run("Programming mode did not end after the load frame");
    end
    assert (core_rst_n_o === 1'b1)
      else abort_run($sformatf("FAIL %0t: core reset still held after load", $time));
    for (w = 0; w < n; w++) begin
      model_mem[w] = words[w];
    end
  endtask

  // One bus transfer, returns read data and cycles until ready
  task automatic bus_access(input word_t addr, input strb_t strb, input word_t wdata,
                            output word_t rdata, output int cycles);
    bit got;
    iomem_valid_i = 1'b1;
    iomem_addr_i  = addr;
    iomem_wstrb_i = strb;
    iomem_wdata_i = wdata;
    cycles = 0;
    got    = 1'b0;
    while (!got && cycles < BUS_TIMEOUT) begin
      @(negedge clk_i);
      cycles++;
      got = (iomem_ready_o === 1'b1);
    end
    if (!got) begin
      abort_run($sformatf("No bus ready for address %h within %0d cycles", addr, BUS_TIMEOUT));
    end
    rdata = iomem_rdata_o;
    iomem_valid_i = 1'b0;
    iomem_addr_i  = '0;
    iomem_wstrb_i = '0;
    iomem_wdata_i = '0;
    @(negedge clk_i);
    assert (iomem_ready_o === 1'b0)
      else abort_run($sformatf("FAIL %0t: ready longer than one cycle at %h", $time, addr));
  endtask

  task automatic add_op(input op_kind_e kind, input word_t addr, input strb_t strb,
                        input word_t data, input word_t exp);
    op_t op;
    op.kind = kind;
    op.addr = addr;
    op.strb = strb;
    op.data = data;
    op.exp  = exp;
    ops.push_back(op);
  endtask

  task automatic apply_ops();
    op_t   op;
    word_t rdata;
    int    cycles;
    int    k;
    for (k = 0; k < ops.size(); k++) begin
      op = ops[k];
      bus_access(op.addr, (op.kind == OP_WR) ? op.strb : 4'b0000, op.data, rdata, cycles);
      assert (cycles == expected_latency(op.addr))
        else abort_run($sformatf("FAIL %0t: ready after %0d cycles at %h, expected %0d",
                                 $time, cycles, op.addr, expected_latency(op.addr)));
      case (op.kind)
        OP_WR: begin
          if (is_ram(op.addr)) begin
            model_mem[ram_index(op.addr)] =
              merge_bytes(model_mem[ram_index(op.addr)], op.data, op.strb);
          end
        end
        OP_RD_RAM: check_word($sformatf("RAM word %0d", ram_index(op.addr)), rdata,
                              model_mem[ram_index(op.addr)]);
        default: check_word($sformatf("address %h", op.addr), rdata, op.exp);
      endcase
    end
  endtask

  task automatic check_timer();
    word_t lo1;
    word_t lo2;
    word_t hi;
    int    cycles;
    int    t1;
    int    t2;
    bus_access(`SOC_TIMER_LO_ADDR, 4'b0000, '0, lo1, cycles);
    t1 = cyc_cnt;
    assert (cycles == 1)
      else abort_run($sformatf("FAIL %0t: timer low ready after %0d cycles", $time, cycles));
    repeat ($urandom_range(20, 3)) @(negedge clk_i);
    bus_access(`SOC_TIMER_LO_ADDR, 4'b0000, '0, lo2, cycles);
    t2 = cyc_cnt;
    assert (lo2 - lo1 >= word_t'(t2 - t1))
      else abort_run($sformatf("FAIL %0t: timer moved %0d in %0d cycles",
                               $time, lo2 - lo1, t2 - t1));
    bus_access(`SOC_TIMER_HI_ADDR, 4'b0000, '0, hi, cycles);
    assert (cycles == 1)
      else abort_run($sformatf("FAIL %0t: timer high ready after %0d cycles", $time, cycles));
    check_word("timer high", hi, 32'h0);
  endtask

  //////////////////////////////
  // Main sequence
  //////////////////////////////

  initial begin
    word_t frame [$];
    word_t addr;
    int    i;
    void'($urandom(16));
    rst_n         = 1'b0;
    program_rx_i  = 1'b1;
    iomem_valid_i = 1'b0;
    iomem_wstrb_i = '0;
    iomem_addr_i  = '0;
    iomem_wdata_i = '0;
    repeat (8) @(negedge clk_i);
    assert (core_rst_n_o === 1'b0)
      else abort_run($sformatf("FAIL %0t: core reset not held during reset", $time));
    rst_n = 1'b1;
    @(negedge clk_i);
    assert (iomem_ready_o === 1'b0 && prog_mode_led_o === 1'b0 && core_rst_n_o === 1'b1)
      else abort_run($sformatf("FAIL %0t: outputs not idle after reset", $time));

    // First program load of four words
    for (i = 0; i < 4; i++) begin
      frame.push_back($urandom());
    end
    load_program(frame);
    for (i = 0; i < 4; i++) begin
      add_op(OP_RD_RAM, RAM_BASE + 4 * i, '0, '0, '0);
    end

    // Full words, then single bytes
    for (i = 4; i < 8; i++) begin
      add_op(OP_WR, RAM_BASE + 4 * i, 4'hF, $urandom(), '0);
      add_op(OP_RD_RAM, RAM_BASE + 4 * i, '0, '0, '0);
    end
    for (i = 0; i < 8; i++) begin
      addr = RAM_BASE + 4 * (4 + $urandom_range(3, 0));
      add_op(OP_WR, addr, strb_t'(1 << $urandom_range(3, 0)), $urandom(), '0);
      add_op(OP_RD_RAM, addr, '0, '0, '0);
    end

    // Unmapped space reads zero and writes nowhere
    add_op(OP_RD_EXP, UNMAPPED, '0, '0, 32'h0);
    add_op(OP_RD_EXP, 32'h3000_0008, '0, '0, 32'h0);
    add_op(OP_WR, UNMAPPED, 4'hF, $urandom(), '0);
    for (i = 0; i < 8; i++) begin
      add_op(OP_RD_RAM, RAM_BASE + 4 * i, '0, '0, '0);
    end
    apply_ops();

    check_timer();

    // Second frame rewrites words 0 and 1 only
    frame.delete();
    frame.push_back($urandom());
    frame.push_back($urandom());
    load_program(frame);
    ops.delete();
    for (i = 0; i < 4; i++) begin
      add_op(OP_RD_RAM, RAM_BASE + 4 * i, '0, '0, '0);
    end
    apply_ops();

    if (i_soc_mem_top.i_soc_mem_asserts.fail_cnt != 0) begin
      abort_run($sformatf("Protocol assertions failed %0d times",
                          i_soc_mem_top.i_soc_mem_asserts.fail_cnt));
    end else begin
      $display("SIMULATION PASSED");
      $finish;
    end
  end

endmodule

// File: uart_program_loader.sv
`timescale 1ns/1ps
`include "soc_cfg.svh"

module uart_program_loader (
  input  logic                      clk_i,
  input  logic                      rst_n,
  input  logic                      program_rx_i,
  output logic                      prog_we_o,
  output soc_prog_pkg::word_index_t prog_addr_o,
  output soc_bus_pkg::word_t        prog_wdata_o,
  output logic                      prog_mode_o,
  output logic                      sys_rst_n_o
);

  localparam int CPB   = `SOC_CLKS_PER_BIT;
  localparam int CNT_W = $clog2(CPB);
  localparam soc_prog_pkg::byte_t START_BYTE = `SOC_PROG_START;

  logic [1:0]                  rx_sync_q;
  logic                        rx_line;
  logic                        rx_busy_q;
  logic [CNT_W-1:0]            rx_clk_cnt_q;
  logic [3:0]                  rx_bit_cnt_q;
  logic                        sample_tick;
  soc_prog_pkg::byte_t         rx_shift_q;
  logic                        byte_stb_q;
  soc_prog_pkg::loader_state_e state_q;
  soc_prog_pkg::byte_lane_t    lane_q;
  soc_prog_pkg::byte_t         words_left_q;
  soc_prog_pkg::word_index_t   wr_idx_q;
  soc_bus_pkg::word_t          word_q;
  logic                        we_q;

  //////////////////////////////
  // Serial receiver, 8N1
  //////////////////////////////

  always_ff @(posedge clk_i) begin
    if (!rst_n) begin
      rx_sync_q <= 2'b11;
    end else begin
      rx_sync_q <= {rx_sync_q[0], program_rx_i};
    end
  end

  assign rx_line     = rx_sync_q[1];
  assign sample_tick = rx_busy_q & (rx_clk_cnt_q == '0);

  // Bit 0 is start, 1 to 8 data, 9 stop
  always_ff @(posedge clk_i) begin
    if (!rst_n) begin
      rx_busy_q    <= 1'b0;
      rx_clk_cnt_q <= '0;
      rx_bit_cnt_q <= '0;
      byte_stb_q   <= 1'b0;
    end else begin
      byte_stb_q <= 1'b0;
      if (!rx_busy_q) begin
        if (!rx_line) begin
          // Wait half a bit to land mid start bit
          rx_busy_q    <= 1'b1;
          rx_clk_cnt_q <= CNT_W'(CPB/2 - 1);
          rx_bit_cnt_q <= '0;
        end
      end else if (!sample_tick) begin
        rx_clk_cnt_q <= rx_clk_cnt_q - 1'b1;
      end else begin
        rx_clk_cnt_q <= CNT_W'(CPB - 1);
        rx_bit_cnt_q <= rx_bit_cnt_q + 1'b1;
        if (rx_bit_cnt_q == 4'd0 && rx_line) begin
          rx_busy_q <= 1'b0;  // glitch, not a start bit
        end else if (rx_bit_cnt_q == 4'd9) begin
          rx_busy_q  <= 1'b0;
          byte_stb_q <= rx_line;
        end
      end
    end
  end

  // LSB first
  always_ff @(posedge clk_i) begin
    if (sample_tick && rx_bit_cnt_q >= 4'd1 && rx_bit_cnt_q <= 4'd8) begin
      rx_shift_q <= {rx_line, rx_shift_q[7:1]};
    end
  end

  //////////////////////////////
  // Frame FSM
  //////////////////////////////

  always_ff @(posedge clk_i) begin
    if (!rst_n) begin
      state_q      <= soc_prog_pkg::LD_IDLE;
      lane_q       <= '0;
      words_left_q <= '0;
      wr_idx_q     <= '0;
      we_q         <= 1'b0;
    end else begin
      we_q <= 1'b0;
      if (we_q) begin
        wr_idx_q <= wr_idx_q + 1'b1;
      end
      case (state_q)
        soc_prog_pkg::LD_IDLE: begin
          if (byte_stb_q && rx_shift_q == START_BYTE) begin
            state_q <= soc_prog_pkg::LD_COUNT;
          end
        end
        soc_prog_pkg::LD_COUNT: begin
          if (byte_stb_q) begin
            words_left_q <= rx_shift_q;
            lane_q       <= '0;
            wr_idx_q     <= '0;
            state_q      <= (rx_shift_q == '0) ? soc_prog_pkg::LD_DONE
                                               : soc_prog_pkg::LD_DATA;
          end
        end
        soc_prog_pkg::LD_DATA: begin
          if (byte_stb_q) begin
            lane_q <= lane_q + 1'b1;
            if (lane_q == 2'd3) begin
              we_q         <= 1'b1;
              words_left_q <= words_left_q - 1'b1;
              if (words_left_q == 8'd1) begin
                state_q <= soc_prog_pkg::LD_DONE;
              end
            end
          end
        end
        // Last write is in flight here
        soc_prog_pkg::LD_DONE: state_q <= soc_prog_pkg::LD_IDLE;
        default: state_q <= soc_prog_pkg::LD_IDLE;
      endcase
    end
  end

  // Little-endian word assembly
  always_ff @(posedge clk_i) begin
    if (state_q == soc_prog_pkg::LD_DATA && byte_stb_q) begin
      word_q <= {rx_shift_q, word_q[31:8]};
    end
  end

  assign prog_we_o    = we_q;
  assign prog_addr_o  = wr_idx_q;
  assign prog_wdata_o = word_q;
  assign prog_mode_o  = (state_q != soc_prog_pkg::LD_IDLE);

  // Core stays in reset while a program is loading
  assign sys_rst_n_o = rst_n & ~prog_mode_o;

endmodule
